/* logic/arp_pkg.sv */
`default_nettype none

package arp_pkg;

	//////////////////////////////////////////////////
	// Widths with a meaning

	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ipv4_addr_t;
	// First byte on the wire sits in bits 31..24
	typedef logic [31:0] word_t;
	// Valid bytes in one word, 1 to 4
	typedef logic [2:0]  byte_count_t;

	//////////////////////////////////////////////////
	// Protocol constants

	localparam logic [15:0] ETHERTYPE_ARP    = 16'h0806;
	localparam logic [15:0] ETHERTYPE_IPV4   = 16'h0800;
	localparam logic [15:0] ARP_HW_ETHERNET  = 16'h0001;
	// HLEN 6 in the high byte and PLEN 4 in the low byte
	localparam logic [15:0] ARP_ADDR_LENGTHS = 16'h0604;
	localparam logic [15:0] ARP_OP_REQUEST   = 16'h0001;
	localparam logic [15:0] ARP_OP_REPLY     = 16'h0002;
	// 28-byte ARP body in 32-bit words
	localparam int REPLY_PAYLOAD_WORDS = 7;

	//////////////////////////////////////////////////
	// Bus structs

	// Receive stream from the MAC and payload stream after the decoder
	typedef struct packed {
		logic        start;
		logic        data_valid;
		byte_count_t bytes_valid;
		word_t       data;
		logic        commit;
		logic        drop;
	} eth_bus_t;

	// Layer 2 verdict, one pulse per frame
	typedef struct packed {
		logic headers_valid;
		logic ethertype_is_arp;
	} l2_status_t;

	// Reply payload from responder to framer
	typedef struct packed {
		logic      start;
		logic      data_valid;
		word_t     data;
		mac_addr_t dst_mac;
		logic      commit;
		logic      drop;
	} reply_stream_t;

	// Outgoing frame words
	typedef struct packed {
		logic  start;
		logic  data_valid;
		word_t data;
		logic  last;
	} tx_frame_t;

endpackage

`default_nettype wire

/* logic/eth_rx_header_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_rx_header_decoder (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire arp_pkg::mac_addr_t our_mac,
	input  wire arp_pkg::eth_bus_t  rx,
	output arp_pkg::eth_bus_t   payload,
	output arp_pkg::l2_status_t status
);

	// Counter stops here, everything after is payload
	localparam logic [2:0] WORD_PAYLOAD = 3'd4;

	logic [2:0] word_cnt;

	// Upper destination MAC from word 0
	logic [15:0] dst_mac_hi;
	// Full destination MAC as word 1 arrives
	arp_pkg::mac_addr_t dst_mac_full;
	logic dst_match;

	// Word 3 carries the ethertype in its low half
	logic at_ethertype;

	// Tracks the verdict already given for this frame
	logic headers_seen;

	assign dst_mac_full = {dst_mac_hi, rx.data};
	assign at_ethertype = rx.data_valid && (word_cnt == 3'd3);

	//////////////////////////////////////////////////
	// Header field capture

	always_ff @(posedge clk) begin
		// Word 0 has the 2 pad bytes up front
		if (rx.data_valid && (word_cnt == 3'd0))
			dst_mac_hi <= rx.data[15:0];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			word_cnt  <= '0;
			dst_match <= 1'b0;
			payload   <= '0;
			status    <= '0;
		end else begin
			// Every field goes out one cycle later
			payload.start       <= rx.start;
			payload.commit      <= rx.commit;
			payload.drop        <= rx.drop;
			payload.bytes_valid <= rx.bytes_valid;
			payload.data        <= rx.data;

			// Only payload words are marked valid downstream
			payload.data_valid <= rx.data_valid && (word_cnt == WORD_PAYLOAD);

			// Destination mismatch folds into the ARP flag
			status.headers_valid    <= at_ethertype;
			status.ethertype_is_arp <= at_ethertype && dst_match &&
				(rx.data[15:0] == arp_pkg::ETHERTYPE_ARP);

			// Word position within the padded frame
			if (rx.start)
				word_cnt <= '0;
			else if (rx.data_valid && (word_cnt != WORD_PAYLOAD))
				word_cnt <= word_cnt + 3'd1;

			// Ours or broadcast
			if (rx.start)
				dst_match <= 1'b0;
			else if (rx.data_valid && (word_cnt == 3'd1))
				dst_match <= (dst_mac_full == our_mac) || (dst_mac_full == '1);
		end
	end

	//////////////////////////////////////////////////
	// Checks

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			headers_seen <= 1'b0;
		else if (payload.start)
			headers_seen <= 1'b0;
		else if (status.headers_valid)
			headers_seen <= 1'b1;
	end

	// One verdict per frame, between two forwarded starts
	assert property (@(posedge clk) disable iff (!arst_n)
		status.headers_valid |-> !headers_seen);

endmodule

`default_nettype wire

/* logic/arp_responder.sv */
`timescale 1ns/1ps
`default_nettype none

module arp_responder (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire arp_pkg::mac_addr_t  our_mac,
	input  wire arp_pkg::ipv4_addr_t our_ip,
	input  wire arp_pkg::eth_bus_t   payload,
	input  wire arp_pkg::l2_status_t status,
	output arp_pkg::reply_stream_t reply
);

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_HEADER,
		ST_BODY_0,
		ST_BODY_1,
		ST_BODY_2,
		ST_BODY_3,
		ST_BODY_4,
		ST_BODY_5,
		ST_BODY_6,
		ST_COMMIT
	} state_t;

	state_t state;

	// Fields picked out of the request
	arp_pkg::mac_addr_t  sender_mac;
	arp_pkg::ipv4_addr_t sender_ip;
	arp_pkg::ipv4_addr_t target_ip;

	logic in_body;
	logic in_frame;
	logic short_word;
	// Cut the reply off and return to idle
	logic abort;

	assign in_body    = (state >= ST_BODY_0) && (state <= ST_BODY_6);
	assign in_frame   = (state != ST_IDLE) && (state != ST_COMMIT);
	assign short_word = payload.data_valid && (payload.bytes_valid != 3'd4);
	// Frame ended early or a body word came in short
	assign abort = (in_frame && payload.commit) || (in_body && short_word);

	//////////////////////////////////////////////////
	// Request field capture

	always_ff @(posedge clk) begin
		if (payload.data_valid) begin
			case (state)
				ST_BODY_2: sender_mac[47:16] <= payload.data;
				ST_BODY_3: begin
					sender_mac[15:0] <= payload.data[31:16];
					sender_ip[31:16] <= payload.data[15:0];
				end
				// Target MAC in the rest of words 4 and 5 is not needed
				ST_BODY_4: sender_ip[15:0] <= payload.data[31:16];
				ST_BODY_6: target_ip <= payload.data;
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Request parsing and reply build

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			reply <= '0;
		end else begin
			// Start goes straight through
			reply.start      <= payload.start;
			reply.data_valid <= 1'b0;
			reply.commit     <= 1'b0;
			reply.drop       <= 1'b0;

			if (payload.drop) begin
				// Input gave up on the frame
				reply.drop <= 1'b1;
				state      <= ST_IDLE;
			end else if (payload.start) begin
				state <= ST_HEADER;
			end else if (abort) begin
				reply.drop <= 1'b1;
				state      <= ST_IDLE;
			end else begin
				case (state)
					// Wait for the L2 verdict
					ST_HEADER: begin
						if (status.headers_valid) begin
							if (status.ethertype_is_arp) begin
								state <= ST_BODY_0;
							end else begin
								reply.drop <= 1'b1;
								state      <= ST_IDLE;
							end
						end
					end

					// HTYPE and PTYPE
					ST_BODY_0: begin
						if (payload.data_valid) begin
							if (payload.data ==
								{arp_pkg::ARP_HW_ETHERNET, arp_pkg::ETHERTYPE_IPV4}) begin
								reply.data_valid <= 1'b1;
								reply.data <=
									{arp_pkg::ARP_HW_ETHERNET, arp_pkg::ETHERTYPE_IPV4};
								state <= ST_BODY_1;
							end else begin
								reply.drop <= 1'b1;
								state      <= ST_IDLE;
							end
						end
					end

					// HLEN, PLEN and operation
					ST_BODY_1: begin
						if (payload.data_valid) begin
							if ((payload.data[31:16] == arp_pkg::ARP_ADDR_LENGTHS) &&
								(payload.data[15:0] == arp_pkg::ARP_OP_REQUEST)) begin
								reply.data_valid <= 1'b1;
								reply.data <= {arp_pkg::ARP_ADDR_LENGTHS, arp_pkg::ARP_OP_REPLY};
								state      <= ST_BODY_2;
							end else begin
								// Replies and unknown ops get no answer
								reply.drop <= 1'b1;
								state      <= ST_IDLE;
							end
						end
					end

					// Our MAC goes out as the sender
					ST_BODY_2: begin
						if (payload.data_valid) begin
							reply.data_valid <= 1'b1;
							reply.data       <= our_mac[47:16];
							state            <= ST_BODY_3;
						end
					end

					ST_BODY_3: begin
						if (payload.data_valid) begin
							reply.data_valid <= 1'b1;
							reply.data       <= {our_mac[15:0], our_ip[31:16]};
							state            <= ST_BODY_4;
						end
					end

					// Sender MAC is complete from here on
					ST_BODY_4: begin
						if (payload.data_valid) begin
							reply.data_valid <= 1'b1;
							reply.data       <= {our_ip[15:0], sender_mac[47:32]};
							reply.dst_mac    <= sender_mac;
							state            <= ST_BODY_5;
						end
					end

					ST_BODY_5: begin
						if (payload.data_valid) begin
							reply.data_valid <= 1'b1;
							reply.data       <= sender_mac[31:0];
							state            <= ST_BODY_6;
						end
					end

					// Target IP arrives with this word
					ST_BODY_6: begin
						if (payload.data_valid) begin
							reply.data_valid <= 1'b1;
							reply.data       <= sender_ip;
							state            <= ST_COMMIT;
						end
					end

					// Skip trailing padding until the frame ends
					ST_COMMIT: begin
						if (payload.commit) begin
							if (target_ip == our_ip)
								reply.commit <= 1'b1;
							else
								reply.drop <= 1'b1;
							state <= ST_IDLE;
						end
					end

					default: ;
				endcase
			end
		end
	end

	// A reply ends one way only
	assert property (@(posedge clk) disable iff (!arst_n)
		!(reply.commit && reply.drop));

endmodule

`default_nettype wire

/* logic/arp_reply_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module arp_reply_framer (
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire arp_pkg::mac_addr_t     our_mac,
	input  wire arp_pkg::reply_stream_t reply,
	output arp_pkg::tx_frame_t       tx
);

	// Destination, source and ethertype in 4 words
	localparam logic [3:0] HDR_WORDS = 4'd4;
	localparam logic [3:0] LAST_IDX  =
		HDR_WORDS + 4'(arp_pkg::REPLY_PAYLOAD_WORDS) - 4'd1;
	localparam logic [2:0] FULL_CNT  = 3'(arp_pkg::REPLY_PAYLOAD_WORDS);

	// One reply payload
	arp_pkg::word_t payload_mem [arp_pkg::REPLY_PAYLOAD_WORDS];
	logic [2:0] wr_cnt;
	arp_pkg::mac_addr_t dst_mac;

	logic       sending;
	logic [3:0] out_idx;
	logic [2:0] rd_idx;
	// Commit with a full buffer starts a frame
	logic       launch;
	logic       emit;
	arp_pkg::word_t frame_word;

	assign launch = reply.commit && (wr_cnt == FULL_CNT) && !sending;
	assign emit   = launch || sending;
	assign rd_idx = 3'(out_idx - HDR_WORDS);

	//////////////////////////////////////////////////
	// Outgoing word select

	always_comb begin
		case (out_idx)
			// 2 pad bytes keep the body word aligned
			4'd0:    frame_word = {16'h0000, dst_mac[47:32]};
			4'd1:    frame_word = dst_mac[31:0];
			4'd2:    frame_word = our_mac[47:16];
			4'd3:    frame_word = {our_mac[15:0], arp_pkg::ETHERTYPE_ARP};
			default: frame_word = payload_mem[rd_idx];
		endcase
	end

	//////////////////////////////////////////////////
	// Payload buffer

	always_ff @(posedge clk) begin
		if (reply.data_valid && (wr_cnt != FULL_CNT)) begin
			payload_mem[wr_cnt] <= reply.data;
			// Fifth word brings the destination MAC
			if (wr_cnt == 3'd4)
				dst_mac <= reply.dst_mac;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_cnt  <= '0;
			sending <= 1'b0;
			out_idx <= '0;
			tx      <= '0;
		end else begin
			// Empty the buffer at the end of each reply
			if (reply.start || reply.drop || reply.commit)
				wr_cnt <= '0;
			else if (reply.data_valid && (wr_cnt != FULL_CNT))
				wr_cnt <= wr_cnt + 3'd1;

			// 11 words back to back
			tx.start      <= launch;
			tx.data_valid <= emit;
			tx.last       <= emit && (out_idx == LAST_IDX);
			if (emit)
				tx.data <= frame_word;

			if (emit) begin
				if (out_idx == LAST_IDX) begin
					out_idx <= '0;
					sending <= 1'b0;
				end else begin
					out_idx <= out_idx + 4'd1;
					sending <= 1'b1;
				end
			end
		end
	end

	// The next reply may only fill slots already sent, and never commits mid frame
	assert property (@(posedge clk) disable iff (!arst_n)
		sending |-> !reply.commit &&
			(!reply.data_valid || (({1'b0, wr_cnt} + HDR_WORDS) < out_idx)));

endmodule

`default_nettype wire

/* logic/arp_offload_top.sv */
`timescale 1ns/1ps
`default_nettype none

module arp_offload_top (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire arp_pkg::mac_addr_t  our_mac,
	input  wire arp_pkg::ipv4_addr_t our_ip,
	input  wire arp_pkg::eth_bus_t   rx,
	output arp_pkg::tx_frame_t    tx
);

	//////////////////////////////////////////////////
	// Stage links

	// Payload words and frame strobes after the L2 header
	arp_pkg::eth_bus_t      payload;
	arp_pkg::l2_status_t    status;
	// Reply body headed for the framer
	arp_pkg::reply_stream_t reply;

	eth_rx_header_decoder u_decoder (
		.clk     (clk),
		.arst_n  (arst_n),
		.our_mac (our_mac),
		.rx      (rx),
		.payload (payload),
		.status  (status)
	);

	arp_responder u_responder (
		.clk     (clk),
		.arst_n  (arst_n),
		.our_mac (our_mac),
		.our_ip  (our_ip),
		.payload (payload),
		.status  (status),
		.reply   (reply)
	);

	// Holds the reply until commit
	arp_reply_framer u_framer (
		.clk     (clk),
		.arst_n  (arst_n),
		.our_mac (our_mac),
		.reply   (reply),
		.tx      (tx)
	);

endmodule

`default_nettype wire

/* bench/arp_reply_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module arp_reply_checker (
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire arp_pkg::mac_addr_t  our_mac,
	input  wire arp_pkg::ipv4_addr_t our_ip,
	input  wire arp_pkg::eth_bus_t   rx,
	input  wire arp_pkg::tx_frame_t  tx,
	input  wire [127:0]              test_name,
	output logic                     check_error,
	output int                       pending
);

	arp_pkg::word_t rx_words[$];
	logic [3:0]     rx_bytes[$];
	// Expected output words and the cycle each reply must start in
	arp_pkg::word_t exp_q[$];
	int             start_q[$];
	int             cycle_cnt;
	int             out_pos;
	arp_pkg::word_t exp_word;
	int             exp_cycle;
	logic           reply_due;
	arp_pkg::mac_addr_t  smac;
	arp_pkg::ipv4_addr_t sip;

	initial begin
		check_error = 1'b0;
		cycle_cnt   = 0;
		out_pos     = 0;
	end

	always_comb begin
		pending   = exp_q.size();
		exp_word  = (exp_q.size() != 0) ? exp_q[0] : '0;
		exp_cycle = (start_q.size() != 0) ? start_q[0] : -1;
	end

	//////////////////////////////////////////////////
	// Reply prediction from the receive stream

	always @(posedge clk) begin
		if (rx.start) begin
			rx_words.delete();
			rx_bytes.delete();
		end
		if (rx.data_valid) begin
			rx_words.push_back(rx.data);
			rx_bytes.push_back({1'b0, rx.bytes_valid});
		end
		if (rx.drop) begin
			rx_words.delete();
			rx_bytes.delete();
		end
		if (rx.commit && rx_words.size() >= 11) begin
			// Header words 0..3, ARP body in words 4..10
			reply_due = ({rx_words[0][15:0], rx_words[1]} == our_mac ||
				{rx_words[0][15:0], rx_words[1]} == 48'hffff_ffff_ffff) &&
				rx_words[3][15:0] == 16'h0806 &&
				rx_words[4] == 32'h0001_0800 &&
				rx_words[5] == 32'h0604_0001 &&
				rx_words[10] == our_ip;
			for (int i = 4; i < 11; i++)
				if (rx_bytes[i] != 4'd4)
					reply_due = 1'b0;
			if (reply_due) begin
				smac = {rx_words[6], rx_words[7][31:16]};
				sip  = {rx_words[7][15:0], rx_words[8][31:16]};
				exp_q.push_back({16'h0000, smac[47:32]});
				exp_q.push_back(smac[31:0]);
				exp_q.push_back(our_mac[47:16]);
				exp_q.push_back({our_mac[15:0], 16'h0806});
				exp_q.push_back(32'h0001_0800);
				exp_q.push_back(32'h0604_0002);
				exp_q.push_back(our_mac[47:16]);
				exp_q.push_back({our_mac[15:0], our_ip[31:16]});
				exp_q.push_back({our_ip[15:0], smac[47:32]});
				exp_q.push_back(smac[31:0]);
				exp_q.push_back(sip);
				// Decoder, responder and framer each add one cycle
				start_q.push_back(cycle_cnt + 3);
			end
		end
		if (tx.data_valid && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
			if (out_pos == 0)
				void'(start_q.pop_front());
			out_pos = (out_pos == 10) ? 0 : out_pos + 1;
		end
		cycle_cnt = cycle_cnt + 1;
	end

	//////////////////////////////////////////////////
	// Output checks

	a_due: assert property (@(posedge clk) disable iff (!arst_n)
		tx.data_valid |-> pending != 0)
	else begin
		$display("[ERROR] %0s: output word %h with no reply due", test_name,
			$sampled(tx.data));
		check_error = 1'b1;
	end

	a_word: assert property (@(posedge clk) disable iff (!arst_n)
		tx.data_valid && pending != 0 |-> tx.data == exp_word)
	else begin
		$display("[ERROR] %0s: word %0d expected %h actual %h", test_name,
			$sampled(out_pos), $sampled(exp_word), $sampled(tx.data));
		check_error = 1'b1;
	end

	a_start: assert property (@(posedge clk) disable iff (!arst_n)
		tx.data_valid |-> tx.start == (out_pos == 0))
	else begin
		$display("[ERROR] %0s: start expected %0d actual %0d", test_name,
			$sampled(out_pos) == 0, $sampled(tx.start));
		check_error = 1'b1;
	end

	a_last: assert property (@(posedge clk) disable iff (!arst_n)
		tx.data_valid |-> tx.last == (out_pos == 10))
	else begin
		$display("[ERROR] %0s: last expected %0d actual %0d", test_name,
			$sampled(out_pos) == 10, $sampled(tx.last));
		check_error = 1'b1;
	end

	// Reply begins 3 cycles after the input commit
	a_latency: assert property (@(posedge clk) disable iff (!arst_n)
		tx.start |-> cycle_cnt == exp_cycle)
	else begin
		$display("[ERROR] %0s: start cycle expected %0d actual %0d", test_name,
			$sampled(exp_cycle), $sampled(cycle_cnt));
		check_error = 1'b1;
	end

	a_gapless: assert property (@(posedge clk) disable iff (!arst_n)
		tx.data_valid && !tx.last |=> tx.data_valid)
	else begin
		$display("%0s: reply frame has a gap between words", test_name);
		check_error = 1'b1;
	end

	a_strobes: assert property (@(posedge clk) disable iff (!arst_n)
		!tx.data_valid |-> !tx.start && !tx.last)
	else begin
		$display("%0s: start or last seen without a data word", test_name);
		check_error = 1'b1;
	end

endmodule

`default_nettype wire

/* bench/arp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module arp_tb;

	localparam int NUM_FRAMES     = 21;
	localparam int TIMEOUT_CYCLES = 40 * NUM_FRAMES + 200;
	localparam arp_pkg::word_t HW_OK  = {arp_pkg::ARP_HW_ETHERNET, arp_pkg::ETHERTYPE_IPV4};
	localparam arp_pkg::word_t REQ_OK = {arp_pkg::ARP_ADDR_LENGTHS, arp_pkg::ARP_OP_REQUEST};
	localparam arp_pkg::mac_addr_t BCAST = 48'hffff_ffff_ffff;

	logic                clk;
	logic                arst_n;
	arp_pkg::mac_addr_t  our_mac;
	arp_pkg::ipv4_addr_t our_ip;
	arp_pkg::eth_bus_t   rx;
	arp_pkg::tx_frame_t  tx;

	logic [127:0] test_name;
	logic         check_error;
	int           pending;
	int           cycle_cnt;
	logic [31:0]  seed;

	arp_offload_top u_dut (
		.clk     (clk),
		.arst_n  (arst_n),
		.our_mac (our_mac),
		.our_ip  (our_ip),
		.rx      (rx),
		.tx      (tx)
	);

	arp_reply_checker u_checker (
		.clk         (clk),
		.arst_n      (arst_n),
		.our_mac     (our_mac),
		.our_ip      (our_ip),
		.rx          (rx),
		.tx          (tx),
		.test_name   (test_name),
		.check_error (check_error),
		.pending     (pending)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	//////////////////////////////////////////////////
	// Run limits

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, %0d reply words still due", cycle_cnt, pending);
			$display("CHECKS FAILED");
			$fatal(1, "Run did not finish in time");
		end
	end

	always @(posedge check_error) begin
		$display("CHECKS FAILED");
		$fatal(1, "Reply check raised an error");
	end

	// LCG, numerical recipes constants
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			rx <= '0;
		end
	endtask

	//////////////////////////////////////////////////
	// Request frame builder

	// short_idx marks a 2-byte word, drop_idx sends a drop in place of that word
	task automatic send_frame(input arp_pkg::mac_addr_t dst, input logic [15:0] etype,
		input arp_pkg::word_t hw_word, input arp_pkg::word_t op_word,
		input arp_pkg::ipv4_addr_t tip, input int short_idx, input int drop_idx,
		input int pad_words, input bit gaps);
		arp_pkg::word_t      w[$];
		arp_pkg::mac_addr_t  smac;
		arp_pkg::ipv4_addr_t sip;
		arp_pkg::eth_bus_t   b;
		seed = lcg_next(seed);
		smac[47:16] = seed & 32'hfeff_ffff;
		seed = lcg_next(seed);
		smac[15:0] = seed[31:16];
		seed = lcg_next(seed);
		sip = seed;
		w.push_back({16'h0000, dst[47:32]});
		w.push_back(dst[31:0]);
		w.push_back(smac[47:16]);
		w.push_back({smac[15:0], etype});
		w.push_back(hw_word);
		w.push_back(op_word);
		w.push_back(smac[47:16]);
		w.push_back({smac[15:0], sip[31:16]});
		w.push_back({sip[15:0], 16'h0000});
		w.push_back(32'h0000_0000);
		w.push_back(tip);
		for (int p = 0; p < pad_words; p++)
			w.push_back(32'h0000_0000);
		@(posedge clk);
		b = '0;
		b.start = 1'b1;
		rx <= b;
		for (int i = 0; i < w.size(); i++) begin
			seed = lcg_next(seed);
			if (gaps && seed[25:24] == 2'b00) begin
				@(posedge clk);
				rx <= '0;
			end
			@(posedge clk);
			b = '0;
			if (i == drop_idx) begin
				// Rest of the frame and its commit still follow the drop
				b.drop = 1'b1;
			end else begin
				b.data_valid  = 1'b1;
				b.bytes_valid = (i == short_idx) ? 3'd2 : 3'd4;
				b.data        = w[i];
			end
			rx <= b;
		end
		@(posedge clk);
		b = '0;
		b.commit = 1'b1;
		rx <= b;
	endtask

	task automatic send_request(input arp_pkg::mac_addr_t dst, input bit gaps);
		seed = lcg_next(seed);
		send_frame(dst, arp_pkg::ETHERTYPE_ARP, HW_OK, REQ_OK, our_ip, -1, -1,
			5 + int'(seed[29:28]), gaps);
	endtask

	// Waits for every due reply, then watches for stray output
	task automatic wait_replies();
		// Second edge lets the last commit reach the expected queue
		idle_cycles(2);
		while (pending != 0)
			idle_cycles(1);
		idle_cycles(16);
	endtask

	initial begin
		seed      = 32'hfce3_f440;
		cycle_cnt = 0;
		arst_n    = 1'b0;
		rx        = '0;
		our_mac   = 48'h021a_2b3c_4d5e;
		our_ip    = 32'hc0a8_0a17;
		test_name = "reset";
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		idle_cycles(20);

		test_name = "request";
		for (int k = 0; k < 3; k++) begin
			send_request(our_mac, 1'b1);
			send_request(BCAST, 1'b1);
		end
		wait_replies();

		test_name = "not_for_us";
		send_frame(our_mac, arp_pkg::ETHERTYPE_ARP, HW_OK, REQ_OK, our_ip + 1, -1, -1, 5, 1);
		send_frame(48'h0200_0000_0001, arp_pkg::ETHERTYPE_ARP, HW_OK, REQ_OK, our_ip,
			-1, -1, 5, 1);
		send_frame(our_mac, arp_pkg::ETHERTYPE_IPV4, HW_OK, REQ_OK, our_ip, -1, -1, 5, 1);
		wait_replies();

		test_name = "bad_body";
		send_frame(BCAST, arp_pkg::ETHERTYPE_ARP, HW_OK, 32'h0604_0002, our_ip, -1, -1, 5, 1);
		send_frame(BCAST, arp_pkg::ETHERTYPE_ARP, HW_OK, 32'h0604_0003, our_ip, -1, -1, 5, 1);
		send_frame(BCAST, arp_pkg::ETHERTYPE_ARP, 32'h0006_0800, REQ_OK, our_ip, -1, -1, 5, 1);
		send_frame(BCAST, arp_pkg::ETHERTYPE_ARP, 32'h0001_86dd, REQ_OK, our_ip, -1, -1, 5, 1);
		send_frame(BCAST, arp_pkg::ETHERTYPE_ARP, HW_OK, 32'h0610_0001, our_ip, -1, -1, 5, 1);
		send_frame(BCAST, arp_pkg::ETHERTYPE_ARP, HW_OK, REQ_OK, our_ip, 8, -1, 5, 1);
		wait_replies();

		// Drop lands in the padding after a complete valid body
		test_name = "drop";
		send_frame(our_mac, arp_pkg::ETHERTYPE_ARP, HW_OK, REQ_OK, our_ip, -1, 12, 5, 1);
		send_request(our_mac, 1'b1);
		wait_replies();

		// Minimum frame is 16 words with the alignment pad
		test_name = "back_to_back";
		for (int k = 0; k < 4; k++)
			send_frame(k[0] ? BCAST : our_mac, arp_pkg::ETHERTYPE_ARP, HW_OK, REQ_OK,
				our_ip, -1, -1, 5, 0);
		wait_replies();

		if (pending == 0 && !check_error) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "Replies left outstanding at the end of the run");
		end
	end

endmodule

`default_nettype wire

/* tb.f */
logic/arp_pkg.sv
logic/eth_rx_header_decoder.sv
logic/arp_responder.sv
logic/arp_reply_framer.sv
logic/arp_offload_top.sv
bench/arp_reply_checker.sv
bench/arp_tb.sv

/* Makefile */
# Verilator build for the ARP offload testbench

VERILATOR ?= verilator
TOP       ?= arp_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard logic/*.sv) $(wildcard bench/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
